// File: Makefile
TOP ?= peCubeTb
SEED_LOG ?= sim.log
FILE_LIST ?= build.f
OBJ_DIR ?= obj_dir
VERILATOR ?= verilator
VERILATOR_FLAGS ?= --binary --timing --timescale 1ns/1ps

.PHONY: help test clean

help:
	@echo "make test   build $(TOP) with Verilator, run it into $(SEED_LOG) and check it"
	@echo "make clean  remove $(OBJ_DIR) and $(SEED_LOG)"

test:
	$(VERILATOR) $(VERILATOR_FLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILE_LIST)
	./$(OBJ_DIR)/V$(TOP) > $(SEED_LOG) 2>&1 || true
	@cat $(SEED_LOG)
	@grep -qx "=== PASS ===" $(SEED_LOG) || (echo "test failed, see $(SEED_LOG)"; exit 1)

clean:
	rm -rf $(OBJ_DIR) $(SEED_LOG)

// File: accCtrl.sv
`timescale 1ns/1ps
`default_nettype none

module accCtrl
  import cnnPkg::*;
(
  input  wire       iClk,
  input  wire       rstN,
  input  wire       start,
  input  wire [7:0] tapCount,
  output peCtrlT    peCtrl
);

logic       busy;
logic [7:0] tapsLeft;
// Set alongside macEn when that macEn belongs to the window's last tap.
logic       lastMac;

always_ff @(posedge iClk or negedge rstN) begin
  if (!rstN) begin
    busy     <= 1'b0;
    tapsLeft <= '0;
    lastMac  <= 1'b0;
    peCtrl   <= '0;
  end else begin
    peCtrl.dump <= lastMac;
    if (busy) begin
      // Start is ignored until the running window has seen its last tap.
      peCtrl.clearAcc <= 1'b0;
      peCtrl.macEn    <= 1'b1;
      lastMac         <= (tapsLeft == 8'd1);
      busy            <= (tapsLeft != 8'd1);
      tapsLeft        <= tapsLeft - 8'd1;
    end else if (start && tapCount != 8'd0) begin
      peCtrl.clearAcc <= 1'b1;
      peCtrl.macEn    <= 1'b1;
      lastMac         <= (tapCount == 8'd1);
      busy            <= (tapCount != 8'd1);
      tapsLeft        <= tapCount - 8'd1;
    end else begin
      peCtrl.clearAcc <= 1'b0;
      peCtrl.macEn    <= 1'b0;
      lastMac         <= 1'b0;
    end
  end
end

endmodule

`default_nettype wire

// File: build.f
cnnPkg.sv
inputRouter.sv
macPe.sv
peBlock.sv
accCtrl.sv
peCube.sv
peCubeTb.sv

// File: cnnPkg.sv
`default_nettype none

package cnnPkg;

  // The five routing patterns are only defined for three block rows.
  localparam int blockNum = 3;

  // Largest array count the configuration word can describe.
  localparam int maxArrayNum = 8;

  typedef logic signed [7:0] dataT;

  typedef logic signed [7:0] weightT;

  typedef logic signed [23:0] accT;

  typedef logic [4:0] shiftT;

  // Each pattern names what block rows 2, 1 and 0 of an array receive.
  // d1 is the array's own feature byte, d2 is the shared one.
  //   pat1: d2 d2 d1
  //   pat2: d2 d1 d1
  //   pat3: d1 d1 d1
  //   pat4: d1 d1 d2
  //   pat5: d1 d2 d2
  // Codes 5 to 7 route zero to every row.
  typedef enum logic [2:0] {
    pat1 = 3'd0,
    pat2 = 3'd1,
    pat3 = 3'd2,
    pat4 = 3'd3,
    pat5 = 3'd4
  } patternE;

  // Per-cycle controls shared by every PE in the cube.
  typedef struct packed {
    logic clearAcc;
    logic macEn;
    logic dump;
  } peCtrlT;

  // Static configuration, held constant for the length of a window.
  // Bit i of passLeft makes array i read array i+1's previous tap.
  // Bits at or above arrayNum-1 are ignored.
  typedef struct packed {
    shiftT                    outShift;
    logic [maxArrayNum-2:0]   passLeft;
  } cubeCfgT;

endpackage

`default_nettype wire

// File: inputRouter.sv
`timescale 1ns/1ps
`default_nettype none

module inputRouter
  import cnnPkg::*;
#(
  parameter int arrayNum = 3
) (
  input  wire          iClk,
  input  wire          rstN,
  input  wire dataT    data1 [arrayNum],
  input  wire dataT    data2,
  input  wire patternE pattern [arrayNum],
  output dataT         routed [arrayNum][blockNum]
);

dataT routedNext [arrayNum][blockNum];

always_comb begin
  for (int a = 0; a < arrayNum; a++) begin
    case (pattern[a])
      pat1: begin
        routedNext[a][2] = data2;
        routedNext[a][1] = data2;
        routedNext[a][0] = data1[a];
      end
      pat2: begin
        routedNext[a][2] = data2;
        routedNext[a][1] = data1[a];
        routedNext[a][0] = data1[a];
      end
      pat3: begin
        routedNext[a][2] = data1[a];
        routedNext[a][1] = data1[a];
        routedNext[a][0] = data1[a];
      end
      pat4: begin
        routedNext[a][2] = data1[a];
        routedNext[a][1] = data1[a];
        routedNext[a][0] = data2;
      end
      pat5: begin
        routedNext[a][2] = data1[a];
        routedNext[a][1] = data2;
        routedNext[a][0] = data2;
      end
      default: begin
        routedNext[a][2] = '0;
        routedNext[a][1] = '0;
        routedNext[a][0] = '0;
      end
    endcase
  end
end

// One register stage so the grid lines up with the controller output.
always_ff @(posedge iClk or negedge rstN) begin
  if (!rstN) begin
    routed <= '{default: '0};
  end else begin
    routed <= routedNext;
  end
end

endmodule

`default_nettype wire

// File: macPe.sv
`timescale 1ns/1ps
`default_nettype none

module macPe
  import cnnPkg::*;
(
  input  wire         iClk,
  input  wire         rstN,
  input  wire peCtrlT peCtrl,
  input  wire dataT   data,
  input  wire weightT weight,
  input  wire shiftT  outShift,
  output dataT        result,
  output logic        resultValid
);

accT  acc;
accT  product;
accT  shifted;
dataT saturated;

always_comb begin
  product = accT'(data) * accT'(weight);
end

// Arithmetic shift keeps the sign, then clamp to a signed byte.
always_comb begin
  shifted = acc >>> outShift;
  if (shifted > accT'(127)) begin
    saturated = 8'sd127;
  end else if (shifted < accT'(-128)) begin
    saturated = -8'sd128;
  end else begin
    saturated = shifted[7:0];
  end
end

always_ff @(posedge iClk or negedge rstN) begin
  if (!rstN) begin
    acc <= '0;
  end else if (peCtrl.macEn) begin
    // The first tap of a window restarts the sum with its own product.
    acc <= peCtrl.clearAcc ? product : acc + product;
  end
end

always_ff @(posedge iClk or negedge rstN) begin
  if (!rstN) begin
    resultValid <= 1'b0;
  end else begin
    resultValid <= peCtrl.dump;
  end
end

// A new window may load acc in the dump cycle; the old sum is still read here.
always_ff @(posedge iClk) begin
  if (peCtrl.dump) begin
    result <= saturated;
  end
end

endmodule

`default_nettype wire

// File: peBlock.sv
`timescale 1ns/1ps
`default_nettype none

module peBlock
  import cnnPkg::*;
#(
  parameter int arrayNum = 3
) (
  input  wire                              iClk,
  input  wire                              rstN,
  input  wire peCtrlT                      peCtrl,
  input  wire dataT                        routed [arrayNum][blockNum],
  input  wire weightT                      weight,
  input  wire cubeCfgT                     cfg,
  output wire dataT                        result [arrayNum][blockNum],
  output wire [arrayNum-1:0][blockNum-1:0] resultValid
);

// Data each PE multiplies this cycle, and what it used on the previous tap.
dataT peData [arrayNum][blockNum];
dataT prevData [arrayNum][blockNum];

always_comb begin
  for (int a = 0; a < arrayNum - 1; a++) begin
    for (int b = 0; b < blockNum; b++) begin
      if (cfg.passLeft[a]) begin
        // On the first tap of a window the neighbour has nothing yet.
        peData[a][b] = peCtrl.clearAcc ? dataT'(0) : prevData[a+1][b];
      end else begin
        peData[a][b] = routed[a][b];
      end
    end
  end
  for (int b = 0; b < blockNum; b++) begin
    peData[arrayNum-1][b] = routed[arrayNum-1][b];
  end
end

// Holding the used data makes a chain of pass-left arrays a systolic shift.
always_ff @(posedge iClk) begin
  if (peCtrl.macEn) begin
    prevData <= peData;
  end
end

genvar arrIdx, blkIdx;
generate
  for (arrIdx = 0; arrIdx < arrayNum; arrIdx++) begin : gArray
    for (blkIdx = 0; blkIdx < blockNum; blkIdx++) begin : gBlock
      macPe uPe (
        .iClk       (iClk),
        .rstN       (rstN),
        .peCtrl     (peCtrl),
        .data       (peData[arrIdx][blkIdx]),
        .weight     (weight),
        .outShift   (cfg.outShift),
        .result     (result[arrIdx][blkIdx]),
        .resultValid(resultValid[arrIdx][blkIdx])
      );
    end
  end
endgenerate

endmodule

`default_nettype wire

// File: peCube.sv
`timescale 1ns/1ps
`default_nettype none

module peCube
  import cnnPkg::*;
#(
  parameter int arrayNum = 3,
  parameter int cubeNum  = 3
) (
  input  wire          iClk,
  input  wire          rstN,
  input  wire          start,
  input  wire [7:0]    tapCount,
  input  wire dataT    data1 [arrayNum],
  input  wire dataT    data2,
  input  wire weightT  weight [cubeNum],
  input  wire patternE pattern [arrayNum],
  input  wire cubeCfgT cfg,
  output dataT         result [cubeNum][blockNum][arrayNum],
  output logic [cubeNum-1:0][blockNum-1:0][arrayNum-1:0] resultValid
);

peCtrlT peCtrl;
dataT   routed [arrayNum][blockNum];
weightT weightQ [cubeNum];

wire dataT                        sliceResult [cubeNum][arrayNum][blockNum];
wire [arrayNum-1:0][blockNum-1:0] sliceValid [cubeNum];

accCtrl uCtrl (
  .iClk    (iClk),
  .rstN    (rstN),
  .start   (start),
  .tapCount(tapCount),
  .peCtrl  (peCtrl)
);

inputRouter #(
  .arrayNum(arrayNum)
) uRouter (
  .iClk   (iClk),
  .rstN   (rstN),
  .data1  (data1),
  .data2  (data2),
  .pattern(pattern),
  .routed (routed)
);

// Weights take the same one-cycle delay as the router.
always_ff @(posedge iClk) begin
  weightQ <= weight;
end

genvar cubeIdx;
generate
  for (cubeIdx = 0; cubeIdx < cubeNum; cubeIdx++) begin : gSlice
    peBlock #(
      .arrayNum(arrayNum)
    ) uBlock (
      .iClk       (iClk),
      .rstN       (rstN),
      .peCtrl     (peCtrl),
      .routed     (routed),
      .weight     (weightQ[cubeIdx]),
      .cfg        (cfg),
      .result     (sliceResult[cubeIdx]),
      .resultValid(sliceValid[cubeIdx])
    );
  end
endgenerate

// Outputs are ordered slice, block, array.
always_comb begin
  for (int c = 0; c < cubeNum; c++) begin
    for (int b = 0; b < blockNum; b++) begin
      for (int a = 0; a < arrayNum; a++) begin
        result[c][b][a]      = sliceResult[c][a][b];
        resultValid[c][b][a] = sliceValid[c][a][b];
      end
    end
  end
end

endmodule

`default_nettype wire

// File: peCubeTb.sv
`timescale 1ns/1ps
`default_nettype none

module peCubeTb
  import cnnPkg::*;
();

localparam int arrayNum      = 3;
localparam int cubeNum       = 3;
localparam int clkPeriod     = 40;
localparam int timeoutCycles = 300;

typedef logic [cubeNum-1:0][blockNum-1:0][arrayNum-1:0] validT;

// One input cycle as it is driven onto the DUT ports.
typedef struct packed {
  logic                     start;
  logic [7:0]               count;
  logic [arrayNum-1:0][2:0] pat;
  dataT [arrayNum-1:0]      d1;
  dataT                     d2;
  weightT [cubeNum-1:0]     w;
} tapT;

// Predicted results of one window and the cycle in which its valid pulse is due.
typedef struct packed {
  int                                             due;
  dataT [cubeNum-1:0][blockNum-1:0][arrayNum-1:0] res;
} expectT;

logic       iClk;
logic       rstN;
logic       start;
logic [7:0] tapCount;
dataT       data1 [arrayNum];
dataT       data2;
weightT     weight [cubeNum];
patternE    pattern [arrayNum];
cubeCfgT    cfg;
dataT       result [cubeNum][blockNum][arrayNum];
validT      resultValid;

cubeCfgT cfgNext;
tapT     winTaps[$];
tapT     tapQ[$];
expectT  expQ[$];
int      cycleNum;
int      checkCount;
int      errorCount;

peCube #(
  .arrayNum(arrayNum),
  .cubeNum (cubeNum)
) uut (
  .iClk       (iClk),
  .rstN       (rstN),
  .start      (start),
  .tapCount   (tapCount),
  .data1      (data1),
  .data2      (data2),
  .weight     (weight),
  .pattern    (pattern),
  .cfg        (cfg),
  .result     (result),
  .resultValid(resultValid)
);

initial iClk = 1'b0;
always #(clkPeriod / 2) iClk = ~iClk;

task automatic checkResult(input dataT got, input dataT exp, input string what);
  checkCount++;
  if (got !== exp) begin
    errorCount++;
    $display("CHECK FAILED at %0t: %s is %0d, expected %0d", $time, what, got, exp);
  end
endtask

task automatic checkValid(input validT got, input validT exp, input string what);
  checkCount++;
  if (got !== exp) begin
    errorCount++;
    $display("CHECK FAILED at %0t: %s is %b, expected %b", $time, what, got, exp);
  end
endtask

// Drives the next queued tap (or an idle cycle) and checks the outputs mid-cycle.
task automatic step();
  tapT    t;
  expectT e;
  validT  expValid;
  logic   due;
  @(posedge iClk);
  cycleNum++;
  t = (tapQ.size() > 0) ? tapQ.pop_front() : '0;
  start    <= t.start;
  tapCount <= t.count;
  data2    <= t.d2;
  for (int a = 0; a < arrayNum; a++) begin
    data1[a]   <= t.d1[a];
    pattern[a] <= patternE'(t.pat[a]);
  end
  for (int c = 0; c < cubeNum; c++) begin
    weight[c] <= t.w[c];
  end
  cfg <= cfgNext;
  @(negedge iClk);
  due = (expQ.size() > 0) && (expQ[0].due == cycleNum);
  expValid = '0;
  if (due) begin
    expValid = '1;
  end
  checkValid(resultValid, expValid, $sformatf("resultValid in cycle %0d", cycleNum));
  if (due) begin
    e = expQ.pop_front();
    for (int c = 0; c < cubeNum; c++) begin
      for (int b = 0; b < blockNum; b++) begin
        for (int a = 0; a < arrayNum; a++) begin
          checkResult(result[c][b][a], e.res[c][b][a],
                      $sformatf("result slice %0d block %0d array %0d", c, b, a));
        end
      end
    end
  end
endtask

task automatic drain();
  int waited;
  waited = 0;
  while ((tapQ.size() > 0 || expQ.size() > 0) && waited < timeoutCycles) begin
    step();
    waited++;
  end
  if (expQ.size() > 0) begin
    errorCount++;
    $display("Timed out after %0d cycles waiting for resultValid", waited);
    expQ.delete();
    tapQ.delete();
  end
  // A few quiet cycles catch a valid pulse that lasts too long.
  repeat (2) step();
endtask

function automatic dataT randData();
  return dataT'($urandom());
endfunction

function automatic dataT routeByte(input patternE p, input dataT d1, input dataT d2,
                                   input int row);
  case (p)
    pat1:    return (row == 0) ? d1 : d2;
    pat2:    return (row == 2) ? d2 : d1;
    pat3:    return d1;
    pat4:    return (row == 0) ? d2 : d1;
    pat5:    return (row == 2) ? d1 : d2;
    default: return '0;
  endcase
endfunction

// Reference model of one window held in winTaps.
function automatic expectT modelWindow(input cubeCfgT cf);
  expectT e;
  tapT    tp;
  dataT   used [arrayNum][blockNum];
  dataT   prev [arrayNum][blockNum];
  weightT w;
  int     acc [cubeNum][arrayNum][blockNum];
  int     s;
  e    = '0;
  prev = '{default: '0};
  acc  = '{default: 0};
  for (int t = 0; t < winTaps.size(); t++) begin
    tp = winTaps[t];
    for (int a = 0; a < arrayNum; a++) begin
      for (int b = 0; b < blockNum; b++) begin
        if (a < arrayNum - 1 && cf.passLeft[a]) begin
          used[a][b] = (t == 0) ? dataT'(0) : prev[a+1][b];
        end else begin
          used[a][b] = routeByte(patternE'(tp.pat[a]), tp.d1[a], tp.d2, b);
        end
      end
    end
    for (int c = 0; c < cubeNum; c++) begin
      w = tp.w[c];
      for (int a = 0; a < arrayNum; a++) begin
        for (int b = 0; b < blockNum; b++) begin
          acc[c][a][b] += int'(used[a][b]) * int'(w);
        end
      end
    end
    prev = used;
  end
  for (int c = 0; c < cubeNum; c++) begin
    for (int a = 0; a < arrayNum; a++) begin
      for (int b = 0; b < blockNum; b++) begin
        s = acc[c][a][b] >>> cf.outShift;
        if (s > 127) begin
          s = 127;
        end else if (s < -128) begin
          s = -128;
        end
        e.res[c][b][a] = dataT'(s);
      end
    end
  end
  return e;
endfunction

task automatic buildWindow(input int n);
  tapT                      t;
  logic [arrayNum-1:0][2:0] pats;
  for (int a = 0; a < arrayNum; a++) begin
    pats[a] = 3'($urandom_range(4, 0));
  end
  for (int i = 0; i < n; i++) begin
    t.start = (i == 0);
    t.count = 8'(n);
    t.pat   = pats;
    t.d2    = randData();
    for (int a = 0; a < arrayNum; a++) begin
      t.d1[a] = randData();
    end
    for (int c = 0; c < cubeNum; c++) begin
      t.w[c] = weightT'($urandom());
    end
    winTaps.push_back(t);
  end
endtask

// Queues the window's taps behind any still pending and books its result pulse.
task automatic commitWindow();
  expectT e;
  e = modelWindow(cfgNext);
  foreach (winTaps[i]) begin
    tapQ.push_back(winTaps[i]);
  end
  e.due = cycleNum + tapQ.size() + 3;
  expQ.push_back(e);
  winTaps.delete();
endtask

task automatic testResetState();
  repeat (20) step();
endtask

task automatic testRouting();
  logic [2:0] codes [6];
  tapT        t;
  codes   = '{3'd0, 3'd1, 3'd2, 3'd3, 3'd4, 3'd7};
  cfgNext = '0;
  foreach (codes[k]) begin
    buildWindow(1);
    t     = winTaps[0];
    t.pat = {arrayNum{codes[k]}};
    t.w   = {cubeNum{8'sd1}};
    winTaps[0] = t;
    commitWindow();
    drain();
  end
endtask

// Random full-range bytes give sums of many thousands, so the shift keeps most
// results inside the byte range where every product term shows.
task automatic testAccumulate();
  repeat (8) begin
    cfgNext = '0;
    cfgNext.outShift = shiftT'($urandom_range(11, 7));
    buildWindow($urandom_range(20, 1));
    commitWindow();
    drain();
  end
endtask

task automatic testSaturation();
  shiftT shifts [3];
  tapT   t;
  shifts = '{5'd0, 5'd4, 5'd10};
  foreach (shifts[s]) begin
    cfgNext = '0;
    cfgNext.outShift = shifts[s];
    for (int i = 0; i < 2; i++) begin
      t.start = (i == 0);
      t.count = 8'd2;
      t.pat   = {arrayNum{3'(pat1)}};
      t.d1    = {arrayNum{8'h7f}};
      t.d2    = 8'h80;
      t.w     = {8'sd3, 8'h80, 8'h7f};
      winTaps.push_back(t);
    end
    commitWindow();
    drain();
  end
endtask

task automatic testPassLeft();
  for (int k = 0; k < 6; k++) begin
    cfgNext = '0;
    cfgNext.outShift = 5'd9;
    cfgNext.passLeft = (k == 0) ? '1 : (maxArrayNum - 1)'($urandom());
    buildWindow($urandom_range(12, 2));
    commitWindow();
    drain();
  end
endtask

task automatic testBackToBack();
  int lens [4];
  lens    = '{5, 3, 1, 1};
  cfgNext = '0;
  cfgNext.outShift = 5'd9;
  cfgNext.passLeft = 7'b1;
  for (int k = 0; k < 4; k += 2) begin
    buildWindow(lens[k]);
    commitWindow();
    buildWindow(lens[k+1]);
    commitWindow();
    drain();
  end
endtask

initial begin
  void'($urandom(32'hc997_e86c));
  checkCount = 0;
  errorCount = 0;
  cycleNum   = 0;
  rstN       = 1'b0;
  start      = 1'b0;
  tapCount   = '0;
  data2      = '0;
  cfg        = '0;
  cfgNext    = '0;
  for (int a = 0; a < arrayNum; a++) begin
    data1[a]   = '0;
    pattern[a] = pat1;
  end
  for (int c = 0; c < cubeNum; c++) begin
    weight[c] = '0;
  end
  repeat (5) @(posedge iClk);
  rstN <= 1'b1;
  testResetState();
  testRouting();
  testAccumulate();
  testSaturation();
  testPassLeft();
  testBackToBack();
  $display("Checks run: %0d, errors: %0d", checkCount, errorCount);
  if (errorCount == 0) begin
    $display("=== PASS ===");
  end else begin
    $display("=== FAIL ===");
  end
  $finish;
end

endmodule

`default_nettype wire
